// ==== bench/vdec_ref_model.svh ====
// reference model for the vector decode stage that expands one instruction into its expected beats

// classify by funct6/funct3, then walk vstart..vl two lanes at a time
function automatic void expand_instr(input fetch_req_t req, input csr_state_t c,
                                     input logic [`VDEC_MAX_ELEMS-1:0] mask);
  logic [5:0] f6;
  logic [2:0] f3;
  logic [4:0] imm;
  logic       vm;
  exec_beat_t b;
  offset_t    e;
  offset_t    amt;
  int         move;
  bit         legal;
  f6    = req.instr[31:26];
  f3    = req.instr[14:12];
  imm   = req.instr[19:15];
  vm    = req.instr[25];
  b     = '0;
  move  = 0;
  legal = (req.instr[6:0] == 7'h57) && (c.sew != sew_t'(2'd3));
  b.eew = c.sew;
  b.vd  = req.instr[11:7];
  b.vs1 = imm;
  b.vs2 = req.instr[24:20];
  if ((f3 inside {3'd0, 3'd3, 3'd4}) && (f6 inside {6'd0, 6'd2, 6'd9, 6'd10, 6'd11})) begin
    case (f6)
      6'd0:    b.alu_op = ALU_ADD;
      6'd2:    b.alu_op = ALU_SUB;
      6'd9:    b.alu_op = ALU_AND;
      6'd10:   b.alu_op = ALU_OR;
      default: b.alu_op = ALU_XOR;
    endcase
  end else if ((f3 inside {3'd3, 3'd4}) && (f6 inside {6'd14, 6'd15})) begin
    // 1 slideup, 2 slidedown
    b.alu_op = ALU_SLIDE;
    move     = int'(f6) - 13;
  end else if ((f3 == 3'd6) && (f6 inside {6'd14, 6'd15})) begin
    // 3 slide1up, 4 slide1down
    b.alu_op = ALU_SLIDE;
    move     = int'(f6) - 11;
  end else if ((f3 == 3'd2) && (f6 == 6'd48)) begin
    // vwaddu writes twice the width up to 32 bits
    b.alu_op = ALU_ADD;
    b.eew    = (c.sew == SEW32) ? SEW32 : sew_t'(c.sew + 2'd1);
  end else begin
    legal = 1'b0;
  end
  case (f3)
    3'd3:       b.operand = (move != 0) ? {27'd0, imm} : {{27{imm[4]}}, imm};
    3'd4, 3'd6: b.operand = req.xs1;
    default:    b.operand = {27'd0, imm};
  endcase
  amt = b.operand[7:0];
  if (!legal) begin
    exp_illegal++;
  end else begin
    for (int i = int'(c.vstart); i < int'(c.vl); i += 2) begin
      b.last = (i + 2 >= int'(c.vl));
      for (int k = 0; k < 2; k++) begin
        e = offset_t'(i + k);
        b.vs2_offset[k] = (move == 2) ? e + amt : (move == 4) ? e + 8'd1 : e;
        b.woffset[k]    = (move == 1) ? e + amt : (move == 3) ? e + 8'd1 : e;
        b.wen[k]        = (i + k < int'(c.vl)) && (vm || mask[(i + k) % 16]);
        // xs1 lands in element vl-1, whose source offset is vl
        b.scalar_insert[k] = (move == 4) && (b.vs2_offset[k] == offset_t'(c.vl));
      end
      exp_q.push_back(b);
    end
  end
endfunction

// ==== bench/tb_vector_decode.sv ====
// testbench for the vector decode stage with a random instruction stream checked against a model
`timescale 1ns/1ps
`include "vdec_macros.svh"

module tb_vector_decode;

  import vdec_types_pkg::*;
  import vdec_stage_pkg::*;

  localparam int NUM_INSTR = 200;
  localparam int GROUP_LEN = 4;

  logic                       CLK, nRST, flush, in_req, in_ack, illegal, out_req, out_ack;
  fetch_req_t                 in_data;
  csr_state_t                 csr;
  logic [`VDEC_MAX_ELEMS-1:0] mask_v0;
  exec_beat_t                 out_beat;

  exec_beat_t                 exp_q[$];
  csr_state_t                 cur_csr;
  logic [`VDEC_MAX_ELEMS-1:0] cur_mask;
  int                         exp_illegal = 0;
  int                         got_illegal = 0;
  bit                         hold_ack;
  integer                     seed, ack_seed;

`include "vdec_ref_model.svh"

  vector_decode_stage uut (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    #(NUM_INSTR * 40 * 8);
    abort_run("timeout: the pipeline stopped making progress");
  end

  always @(posedge CLK) begin
    if (illegal) got_illegal <= got_illegal + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_beat(input exec_beat_t got, input exec_beat_t exp);
    if (got !== exp) abort_run($sformatf("Fail out_beat: expected %h, got %h", exp, got));
  endtask

  task automatic check_illegal(input int exp, input int got);
    if (got != exp) abort_run($sformatf("Fail illegal: expected %0h pulses, got %0h", exp, got));
  endtask

  // kept forms plus a few dropped or foreign encodings with random fields
  function automatic fetch_req_t random_instr();
    fetch_req_t req;
    logic [5:0] f6;
    logic [2:0] f3;
    logic [6:0] opc;
    int         pick;
    pick      = {$random(seed)} % 13;
    req.xs1   = $random(seed);
    req.instr = $random(seed);
    opc       = 7'h57;
    f6        = 6'd0;
    f3        = ({$random(seed)} % 2 == 0) ? 3'd3 : 3'd4;
    case (pick)
      0, 1, 2, 3, 4: begin
        f6 = (pick == 0) ? 6'd0 : (pick == 1) ? 6'd2 : 6'(pick + 7);
        if ({$random(seed)} % 3 == 0) f3 = 3'd0;
      end
      5:  {f6, f3} = {6'd48, 3'd2};
      6:  f6 = 6'd14;
      7:  f6 = 6'd15;
      8:  {f6, f3} = {6'd14, 3'd6};
      9:  {f6, f3} = {6'd15, 3'd6};
      // vslideup.vv and vmul are not kept
      10: {f6, f3} = {6'd14, 3'd0};
      11: {f6, f3} = {6'd37, 3'd2};
      default: opc = 7'h07;
    endcase
    req.instr = {f6, req.instr[25:15], f3, req.instr[11:7], opc};
    return req;
  endfunction

  // new csr and mask once the pipeline is empty
  task automatic new_context();
    int         r;
    logic [1:0] s;
    @(posedge CLK);
    r = {$random(seed)} % 8;
    s = (r == 7) ? 2'd3 : 2'(r % 3);
    cur_csr.sew    = sew_t'(s);
    cur_csr.vl     = elem_idx_t'(1 + {$random(seed)} % (16 >> s));
    cur_csr.vstart = elem_idx_t'({$random(seed)} % cur_csr.vl);
    cur_mask       = 16'($random(seed));
    csr     <= cur_csr;
    mask_v0 <= cur_mask;
  endtask

  task automatic send_instr(input fetch_req_t req);
    expand_instr(req, cur_csr, cur_mask);
    @(posedge CLK);
    in_data <= req;
    in_req  <= 1'b1;
    @(posedge CLK);
    while (!in_ack) @(posedge CLK);
    in_req <= 1'b0;
    @(posedge CLK);
    while (in_ack) @(posedge CLK);
  endtask

  task automatic wait_drain();
    @(negedge CLK);
    while (exp_q.size() != 0 || out_req || out_ack || in_ack) @(negedge CLK);
    // room for a stray beat to show up
    repeat (4) @(negedge CLK);
    check_illegal(exp_illegal, got_illegal);
  endtask

  // long vadd.vv flushed while its first beat is held at the output
  task automatic run_flush_case();
    fetch_req_t req;
    hold_ack = 1'b1;
    @(posedge CLK);
    cur_csr  = '{sew: SEW8, vl: elem_idx_t'(16), vstart: '0};
    csr     <= cur_csr;
    req.xs1   = $random(seed);
    req.instr = {6'd0, 1'b1, 5'd3, 5'd2, 3'd0, 5'd1, 7'h57};
    send_instr(req);
    @(negedge CLK);
    while (!out_req) @(negedge CLK);
    @(posedge CLK);
    flush <= 1'b1;
    @(posedge CLK);
    flush <= 1'b0;
    @(negedge CLK);
    while (exp_q.size() > 1) exp_q.delete(exp_q.size() - 1);
    hold_ack = 1'b0;
    wait_drain();
  endtask

  // execute side with a random ack delay and in-order beat checks
  initial begin : collector
    int delay;
    forever begin
      @(posedge CLK);
      if (out_req && !hold_ack) begin
        delay = {$random(ack_seed)} % 4;
        repeat (delay) @(posedge CLK);
        if (exp_q.size() == 0) begin
          abort_run("execute received a beat that no instruction should produce");
        end else begin
          check_beat(out_beat, exp_q.pop_front());
          out_ack <= 1'b1;
          @(posedge CLK);
          while (out_req) @(posedge CLK);
          out_ack <= 1'b0;
        end
      end
    end
  end

  initial begin
    seed     = 32'hb2551755;
    ack_seed = 32'hb2551755;
    nRST     = 1'b0;
    flush    = 1'b0;
    in_req   = 1'b0;
    in_data  = '0;
    csr      = '0;
    mask_v0  = '0;
    out_ack  = 1'b0;
    hold_ack = 1'b0;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    for (int n = 0; n < NUM_INSTR; n += GROUP_LEN) begin
      if (n == NUM_INSTR / 2) run_flush_case();
      new_context();
      for (int j = 0; j < GROUP_LEN; j++) begin
        send_instr(random_instr());
      end
      wait_drain();
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
+incdir+bench
src/vdec_types_pkg.sv
src/vdec_stage_pkg.sv
src/vector_control_unit.sv
src/element_counter.sv
src/operand_offset_gen.sv
src/vector_decode_stage.sv
bench/tb_vector_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the vector decode testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_vector_decode -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vector_decode > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

// ==== src/element_counter.sv ====
// element counter: walks the element index from vstart to vl, two lanes per beat
`timescale 1ns/1ps
`include "vdec_macros.svh"

module element_counter (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          flush,
  input  vdec_stage_pkg::csr_state_t    csr,
  input  logic                          op_valid,
  input  vdec_stage_pkg::decoded_op_t   op,
  output logic                          op_ready,
  output logic                          beat_valid,
  output vdec_stage_pkg::element_beat_t beat,
  input  logic                          beat_ready
);

  import vdec_types_pkg::*;
  import vdec_stage_pkg::*;

  decoded_op_t op_q;
  elem_idx_t   idx;
  elem_idx_t   next_idx;
  logic        busy;
  logic        last;
  logic        fire;
  logic        accept;

  // idx stays below vl so the sum cannot wrap
  assign next_idx = idx + elem_idx_t'(`VDEC_LANES);
  assign last     = (next_idx >= csr.vl);

  assign fire     = busy && beat_ready;
  assign op_ready = !busy || (fire && last);
  assign accept   = op_valid && op_ready;

  assign beat_valid = busy;
  assign beat.op    = op_q;
  assign beat.idx   = idx;
  assign beat.last  = last;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (accept) begin
      // nothing to do when vstart is already at or past vl
      busy <= (csr.vstart < csr.vl);
    end else if (fire && last) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      op_q <= op;
      idx  <= csr.vstart;
    end else if (fire) begin
      idx <= next_idx;
    end
  end

endmodule

// ==== src/operand_offset_gen.sv ====
// operand offset generator for per-lane offsets, write enables and the output handshake
`timescale 1ns/1ps
`include "vdec_macros.svh"

module operand_offset_gen (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          flush,
  input  vdec_stage_pkg::csr_state_t    csr,
  input  logic [`VDEC_MAX_ELEMS-1:0]    mask_v0,
  input  logic                          beat_valid,
  input  vdec_stage_pkg::element_beat_t beat,
  output logic                          beat_ready,
  output logic                          out_req,
  output vdec_stage_pkg::exec_beat_t    out_beat,
  input  logic                          out_ack
);

  import vdec_types_pkg::*;
  import vdec_stage_pkg::*;

  localparam int MASK_SEL_W = $clog2(`VDEC_MAX_ELEMS);

  exec_beat_t next_beat;
  offset_t    vl_off;
  logic       load;

  assign vl_off = offset_t'(csr.vl);

  function automatic offset_t lane_offset(input offset_src_t src, input offset_t e,
                                          input offset_t amount);
    offset_t res;
    case (src)
      SRC_IDX_PLUS_AMT: res = e + amount;
      SRC_IDX_PLUS_1:   res = e + offset_t'(1);
      default:          res = e;
    endcase
    return res;
  endfunction

  always_comb begin
    offset_t e;
    next_beat.alu_op  = beat.op.alu_op;
    next_beat.eew     = beat.op.eew;
    next_beat.vd      = beat.op.vd;
    next_beat.vs1     = beat.op.vs1;
    next_beat.vs2     = beat.op.vs2;
    next_beat.operand = beat.op.operand;
    next_beat.last    = beat.last;
    for (int k = 0; k < `VDEC_LANES; k++) begin
      e = offset_t'(beat.idx) + offset_t'(k);
      next_beat.vs2_offset[k] = lane_offset(beat.op.vs2_src, e, beat.op.amount);
      next_beat.woffset[k]    = lane_offset(beat.op.vd_src, e, beat.op.amount);
      // tail lane of an odd final beat falls outside vl
      next_beat.wen[k] = (e < vl_off) && (beat.op.vm || mask_v0[e[MASK_SEL_W-1:0]]);
      // slide1down takes xs1 at element vl-1, whose source sits at vl
      next_beat.scalar_insert[k] = beat.op.slide1down && (next_beat.vs2_offset[k] == vl_off);
    end
  end

  // next beat only once the previous handshake has fully returned to zero
  assign beat_ready = !out_req && !out_ack;
  assign load       = beat_valid && beat_ready && !flush;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_req <= 1'b0;
    end else if (load) begin
      out_req <= 1'b1;
    end else if (out_req && out_ack) begin
      out_req <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      out_beat <= next_beat;
    end
  end

endmodule

// ==== src/vdec_macros.svh ====
// vector decode sizing: register length, scalar word, lanes and derived field widths
`ifndef VDEC_MACROS_SVH
`define VDEC_MACROS_SVH

// vector register length in bits
`define VDEC_VLEN 128

// scalar word width
`define VDEC_ELEN 32

// elements handed to execute per beat
`define VDEC_LANES 2

// element count at SEW8 with LMUL 1
`define VDEC_MAX_ELEMS (`VDEC_VLEN / 8)

// element index, vl and vstart
`define VDEC_IDX_W 5

// element offsets wrap modulo 256
`define VDEC_OFF_W 8

`endif

// ==== src/vdec_stage_pkg.sv ====
// vector decode stage payloads passed between the pipeline stages and at the ports
`include "vdec_macros.svh"

package vdec_stage_pkg;

  import vdec_types_pkg::*;

  typedef struct packed {
    word_t instr;
    word_t xs1;
  } fetch_req_t;

  typedef struct packed {
    sew_t      sew;
    elem_idx_t vl;
    elem_idx_t vstart;
  } csr_state_t;

  // one classified instruction
  typedef struct packed {
    alu_op_t     alu_op;
    sew_t        eew;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    logic        vm;
    offset_src_t vs2_src;
    offset_src_t vd_src;
    offset_t     amount;
    word_t       operand;
    logic        slide1down;
  } decoded_op_t;

  typedef struct packed {
    decoded_op_t op;
    elem_idx_t   idx;
    logic        last;
  } element_beat_t;

  // what execute sees for each beat
  typedef struct packed {
    alu_op_t                      alu_op;
    sew_t                         eew;
    vreg_t                        vd;
    vreg_t                        vs1;
    vreg_t                        vs2;
    word_t                        operand;
    offset_t [`VDEC_LANES-1:0]    vs2_offset;
    offset_t [`VDEC_LANES-1:0]    woffset;
    logic [`VDEC_LANES-1:0]       wen;
    logic [`VDEC_LANES-1:0]       scalar_insert;
    logic                         last;
  } exec_beat_t;

endpackage

// ==== src/vdec_types_pkg.sv ====
// vector decode field types: widths, register numbers and the decode enums
`include "vdec_macros.svh"

package vdec_types_pkg;

  // scalar operand, xs1 or an extended immediate
  typedef logic [`VDEC_ELEN-1:0] word_t;

  typedef logic [`VDEC_IDX_W-1:0] elem_idx_t;

  typedef logic [`VDEC_OFF_W-1:0] offset_t;

  typedef logic [4:0] vreg_t;

  // encoding 3 is reserved
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLIDE
  } alu_op_t;

  // how a lane offset is formed from the element index
  typedef enum logic [2:0] {
    SRC_NORMAL,
    SRC_IDX_PLUS_AMT,
    SRC_IDX_PLUS_1,
    SRC_IDX_MINUS_1
  } offset_src_t;

  // input four-phase handshake
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_ACK,
    CTRL_WAIT_REQ_LOW
  } ctrl_state_t;

endpackage

// ==== src/vector_control_unit.sv ====
// vector control unit: input handshake, instruction classification and operand selection
`timescale 1ns/1ps
`include "vdec_macros.svh"

module vector_control_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       flush,
  input  logic                       in_req,
  input  vdec_stage_pkg::fetch_req_t in_data,
  input  vdec_stage_pkg::csr_state_t csr,
  output logic                       in_ack,
  output logic                       illegal,
  output logic                       op_valid,
  output vdec_stage_pkg::decoded_op_t op,
  input  logic                       op_ready
);

  import vdec_types_pkg::*;
  import vdec_stage_pkg::*;

  localparam logic [6:0] OPC_OPV  = 7'b1010111;
  localparam logic [2:0] F3_OPIVV = 3'b000;
  localparam logic [2:0] F3_OPMVV = 3'b010;
  localparam logic [2:0] F3_OPIVI = 3'b011;
  localparam logic [2:0] F3_OPIVX = 3'b100;
  localparam logic [2:0] F3_OPMVX = 3'b110;

  localparam logic [5:0] F6_VADD       = 6'b000000;
  localparam logic [5:0] F6_VSUB       = 6'b000010;
  localparam logic [5:0] F6_VAND       = 6'b001001;
  localparam logic [5:0] F6_VOR        = 6'b001010;
  localparam logic [5:0] F6_VXOR       = 6'b001011;
  localparam logic [5:0] F6_VSLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_VSLIDEDOWN = 6'b001111;
  localparam logic [5:0] F6_VWADDU     = 6'b110000;

  ctrl_state_t state, next_state;
  decoded_op_t dec;
  logic        dec_legal;
  logic        illegal_q;
  logic        space;
  logic        take;
  word_t       sext_imm, zext_imm;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [5:0]  funct6;
  logic [4:0]  imm5;

  assign opcode = in_data.instr[6:0];
  assign funct3 = in_data.instr[14:12];
  assign funct6 = in_data.instr[31:26];
  assign imm5   = in_data.instr[19:15];

  assign sext_imm = {{(`VDEC_ELEN-5){imm5[4]}}, imm5};
  assign zext_imm = {{(`VDEC_ELEN-5){1'b0}}, imm5};

  always_comb begin
    dec_legal      = 1'b0;
    dec            = '0;
    dec.alu_op     = ALU_ADD;
    dec.eew        = csr.sew;
    dec.vd         = in_data.instr[11:7];
    dec.vs1        = in_data.instr[19:15];
    dec.vs2        = in_data.instr[24:20];
    dec.vm         = in_data.instr[25];
    dec.vs2_src    = SRC_NORMAL;
    dec.vd_src     = SRC_NORMAL;
    dec.slide1down = 1'b0;
    // .vv forms carry the vs1 field as operand
    dec.operand    = zext_imm;
    if (opcode == OPC_OPV) begin
      case (funct3)
        F3_OPIVV, F3_OPIVX, F3_OPIVI: begin
          dec_legal = 1'b1;
          if (funct3 == F3_OPIVX) begin
            dec.operand = in_data.xs1;
          end else if (funct3 == F3_OPIVI) begin
            dec.operand = sext_imm;
          end
          case (funct6)
            F6_VADD: dec.alu_op = ALU_ADD;
            F6_VSUB: dec.alu_op = ALU_SUB;
            F6_VAND: dec.alu_op = ALU_AND;
            F6_VOR:  dec.alu_op = ALU_OR;
            F6_VXOR: dec.alu_op = ALU_XOR;
            F6_VSLIDEUP, F6_VSLIDEDOWN: begin
              // slide amounts are unsigned
              dec.alu_op = ALU_SLIDE;
              dec_legal  = (funct3 != F3_OPIVV);
              if (funct3 == F3_OPIVI) begin
                dec.operand = zext_imm;
              end
              if (funct6 == F6_VSLIDEUP) begin
                dec.vd_src = SRC_IDX_PLUS_AMT;
              end else begin
                dec.vs2_src = SRC_IDX_PLUS_AMT;
              end
            end
            default: dec_legal = 1'b0;
          endcase
        end
        F3_OPMVV: begin
          if (funct6 == F6_VWADDU) begin
            dec_legal  = 1'b1;
            dec.alu_op = ALU_ADD;
            dec.eew    = (csr.sew == SEW8) ? SEW16 : SEW32;
          end
        end
        F3_OPMVX: begin
          dec.operand = in_data.xs1;
          dec.alu_op  = ALU_SLIDE;
          if (funct6 == F6_VSLIDEUP) begin
            dec_legal  = 1'b1;
            dec.vd_src = SRC_IDX_PLUS_1;
          end else if (funct6 == F6_VSLIDEDOWN) begin
            dec_legal      = 1'b1;
            dec.vs2_src    = SRC_IDX_PLUS_1;
            dec.slide1down = 1'b1;
          end
        end
        default: dec_legal = 1'b0;
      endcase
    end
    if (csr.sew > SEW32) begin
      dec_legal = 1'b0;
    end
    dec.amount = dec.operand[`VDEC_OFF_W-1:0];
  end

  // room when empty or draining this cycle
  assign space = !op_valid || op_ready;
  assign take  = (state == CTRL_IDLE) && in_req && space;

  always_comb begin
    next_state = state;
    case (state)
      CTRL_IDLE: begin
        if (take) begin
          next_state = CTRL_ACK;
        end
      end
      CTRL_ACK:          next_state = in_req ? CTRL_WAIT_REQ_LOW : CTRL_IDLE;
      CTRL_WAIT_REQ_LOW: next_state = in_req ? CTRL_WAIT_REQ_LOW : CTRL_IDLE;
      default:           next_state = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= CTRL_IDLE;
      illegal_q <= 1'b0;
      op_valid  <= 1'b0;
    end else begin
      state <= next_state;
      if (take) begin
        illegal_q <= !dec_legal;
      end
      if (flush) begin
        op_valid <= 1'b0;
      end else if (take) begin
        op_valid <= dec_legal;
      end else if (op_ready) begin
        op_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (take) begin
      op <= dec;
    end
  end

  assign in_ack = (state != CTRL_IDLE);
  // ACK lasts exactly one cycle
  assign illegal = (state == CTRL_ACK) && illegal_q;

endmodule

// ==== src/vector_decode_stage.sv ====
// vector decode stage top: control unit, element counter and offset generator in a chain
`timescale 1ns/1ps
`include "vdec_macros.svh"

module vector_decode_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       flush,
  input  logic                       in_req,
  input  vdec_stage_pkg::fetch_req_t in_data,
  output logic                       in_ack,
  output logic                       illegal,
  input  vdec_stage_pkg::csr_state_t csr,
  input  logic [`VDEC_MAX_ELEMS-1:0] mask_v0,
  output logic                       out_req,
  output vdec_stage_pkg::exec_beat_t out_beat,
  input  logic                       out_ack
);

  import vdec_stage_pkg::*;

  decoded_op_t   op;
  element_beat_t beat;
  logic          op_valid, op_ready;
  logic          beat_valid, beat_ready;

  vector_control_unit vcu (
    .CLK(CLK), .nRST(nRST), .flush(flush),
    .in_req(in_req), .in_data(in_data), .csr(csr),
    .in_ack(in_ack), .illegal(illegal),
    .op_valid(op_valid), .op(op), .op_ready(op_ready)
  );

  element_counter ele_cnt (
    .CLK(CLK), .nRST(nRST), .flush(flush), .csr(csr),
    .op_valid(op_valid), .op(op), .op_ready(op_ready),
    .beat_valid(beat_valid), .beat(beat), .beat_ready(beat_ready)
  );

  operand_offset_gen off_gen (
    .CLK(CLK), .nRST(nRST), .flush(flush), .csr(csr), .mask_v0(mask_v0),
    .beat_valid(beat_valid), .beat(beat), .beat_ready(beat_ready),
    .out_req(out_req), .out_beat(out_beat), .out_ack(out_ack)
  );

endmodule
